/* Makefile */
# Verilator build and run for the filter-condition engine testbench

TOP := tb_filter_cond_engine

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -f filter_cond_engine.f --top-module $(TOP) -o $(TOP)

# Pass only when the simulation output holds the pass line
run: compile
	@out=$$(./obj_dir/$(TOP) +verilator+error+limit+100); \
	echo "$$out"; \
	echo "$$out" | grep -qx "NO ERRORS"

clean:
	rm -rf obj_dir

/* common/filter_cond_params.svh */
// ----------------------------------------------------------
// Widths shared by the filter-condition RTL and testbench
// Threshold width must equal the data width
// The id is zero-extended when it is compared as a field
// ----------------------------------------------------------

`ifndef FILTER_COND_PARAMS_SVH
`define FILTER_COND_PARAMS_SVH

// Vertex id carried in every engine packet
`define FC_ID_W 16

// Packet data word, also the threshold width
`define FC_DATA_W 32

// Packet count in the start descriptor
`define FC_COUNT_W 16

// Configuration slot index
// Slots are 0 op, 1 threshold, 2 field, 3 commit
`define FC_SLOT_W 2

`endif

/* common/filter_cond_pkg.sv */
// ----------------------------------------------------------
// Types for the filter-condition engine
// All comparisons are unsigned, field on the left
// Only CTRL_FILTERED is produced; other kinds are reserved
// ----------------------------------------------------------

`default_nettype none

`include "filter_cond_params.svh"

package filter_cond_pkg;

    // ------------------------------------------------------------
    // Encodings
    // ------------------------------------------------------------
    // Comparison operator, codes 6 and 7 unused
    typedef enum logic [2:0] {
        EQ = 3'd0,
        NE = 3'd1,
        LT = 3'd2,
        GT = 3'd3,
        LE = 3'd4,
        GE = 3'd5
    } cond_op_e;

    // Operand selection for the left side of the compare
    typedef enum logic {
        FIELD_ID   = 1'b0,
        FIELD_DATA = 1'b1
    } field_sel_e;

    // Control packet kind
    typedef enum logic [1:0] {
        CTRL_RESERVED_0 = 2'd0,
        CTRL_FILTERED   = 2'd1,
        CTRL_RESERVED_2 = 2'd2,
        CTRL_RESERVED_3 = 2'd3
    } control_kind_e;

    // ------------------------------------------------------------
    // Packets
    // ------------------------------------------------------------
    typedef struct packed {
        logic [`FC_ID_W-1:0]   id;
        logic [`FC_DATA_W-1:0] data;
    } engine_payload_t;

    typedef struct packed {
        logic            valid;
        engine_payload_t payload;
    } engine_packet_t;

    // Configuration word from the memory side
    typedef struct packed {
        logic                  valid;
        logic [`FC_SLOT_W-1:0] slot;
        logic [`FC_DATA_W-1:0] data;
    } memory_response_t;

    // Start descriptor, count of packets to process
    typedef struct packed {
        logic                   valid;
        logic [`FC_COUNT_W-1:0] count;
    } descriptor_t;

    // Marks a packet as filtered out
    typedef struct packed {
        logic                valid;
        control_kind_e       kind;
        logic [`FC_ID_W-1:0] id;
    } control_packet_t;

    // Committed condition used by the generator
    typedef struct packed {
        logic                  valid;
        cond_op_e              op;
        field_sel_e            field;
        logic [`FC_DATA_W-1:0] threshold;
    } filter_cond_config_t;

endpackage

`default_nettype wire

/* configure_memory/filter_cond_configure_memory.sv */
// ----------------------------------------------------------
// Configuration capture from memory response words
// Slot writes are staged, a slot 3 write commits them
// A later commit replaces the active configuration
// ----------------------------------------------------------

`default_nettype none

`include "filter_cond_params.svh"

module filter_cond_configure_memory (
    input  logic                                 ap_clk,
    input  logic                                 areset_filter_cond_engine,
    input  filter_cond_pkg::memory_response_t    response_memory_in,
    output filter_cond_pkg::filter_cond_config_t config_out
);

    // ------------------------------------------------------------
    // Slot decode
    // ------------------------------------------------------------
    localparam logic [`FC_SLOT_W-1:0] SLOT_OP        = 2'd0;
    localparam logic [`FC_SLOT_W-1:0] SLOT_THRESHOLD = 2'd1;
    localparam logic [`FC_SLOT_W-1:0] SLOT_FIELD     = 2'd2;
    localparam logic [`FC_SLOT_W-1:0] SLOT_COMMIT    = 2'd3;

    // Staged values, not visible to the generator until commit
    filter_cond_pkg::cond_op_e   op_stage;
    filter_cond_pkg::field_sel_e field_stage;
    logic [`FC_DATA_W-1:0]       threshold_stage;

    logic commit;

    assign commit = response_memory_in.valid && (response_memory_in.slot == SLOT_COMMIT);

    // ------------------------------------------------------------
    // Staging registers
    // ------------------------------------------------------------
    // Op takes the low 3 bits, field takes bit 0
    always_ff @(posedge ap_clk) begin
        if (response_memory_in.valid) begin
            case (response_memory_in.slot)
                SLOT_OP:        op_stage <= filter_cond_pkg::cond_op_e'(response_memory_in.data[2:0]);
                SLOT_THRESHOLD: threshold_stage <= response_memory_in.data;
                SLOT_FIELD:     field_stage <= filter_cond_pkg::field_sel_e'(response_memory_in.data[0]);
                default:        ;
            endcase
        end
    end

    // ------------------------------------------------------------
    // Active configuration
    // ------------------------------------------------------------
    // Valid is sticky once committed, cleared only by reset
    always_ff @(posedge ap_clk) begin
        if (areset_filter_cond_engine) begin
            config_out.valid <= 1'b0;
        end else if (commit) begin
            config_out.valid <= 1'b1;
        end
        if (commit) begin
            config_out.op        <= op_stage;
            config_out.field     <= field_stage;
            config_out.threshold <= threshold_stage;
        end
    end

endmodule

`default_nettype wire

/* filter_cond_engine.f */
+incdir+common
common/filter_cond_pkg.sv
configure_memory/filter_cond_configure_memory.sv
generator/filter_cond_generator.sv
rtl/filter_cond_engine.sv
tb/filter_cond_assertions.sv
tb/filter_cond_checker.sv
tb/tb_filter_cond_engine.sv

/* generator/filter_cond_generator.sv */
// ----------------------------------------------------------
// Condition generator, one packet per cycle, 1 cycle latency
// Packets seen before arming are dropped and not counted
// Done stays high until the next descriptor
// A descriptor count of zero never raises done
// ----------------------------------------------------------

`default_nettype none

`include "filter_cond_params.svh"

module filter_cond_generator (
    input  logic                                 ap_clk,
    input  logic                                 areset_filter_cond_engine,
    input  filter_cond_pkg::descriptor_t         descriptor_in,
    input  filter_cond_pkg::filter_cond_config_t config_in,
    input  filter_cond_pkg::engine_packet_t      response_engine_in,
    output filter_cond_pkg::engine_packet_t      request_engine_out,
    output filter_cond_pkg::control_packet_t     request_control_out,
    output logic                                 armed,
    output logic                                 done
);

    // ------------------------------------------------------------
    // State
    // ------------------------------------------------------------
    logic                   started_q;
    logic                   done_q;
    logic [`FC_COUNT_W-1:0] desc_count_q;
    logic [`FC_COUNT_W-1:0] processed_q;
    logic [`FC_COUNT_W-1:0] count_next;

    logic                  accept;
    logic                  pass;
    logic [`FC_DATA_W-1:0] operand;

    // Armed once a config is committed and a descriptor was seen
    assign armed  = started_q & config_in.valid;
    assign accept = response_engine_in.valid & armed;
    assign done   = done_q;

    // ------------------------------------------------------------
    // Condition evaluation
    // ------------------------------------------------------------
    always_comb begin
        // Id is zero-extended to the threshold width
        if (config_in.field == filter_cond_pkg::FIELD_ID) begin
            operand = {{(`FC_DATA_W - `FC_ID_W){1'b0}}, response_engine_in.payload.id};
        end else begin
            operand = response_engine_in.payload.data;
        end
        case (config_in.op)
            filter_cond_pkg::EQ: pass = (operand == config_in.threshold);
            filter_cond_pkg::NE: pass = (operand != config_in.threshold);
            filter_cond_pkg::LT: pass = (operand <  config_in.threshold);
            filter_cond_pkg::GT: pass = (operand >  config_in.threshold);
            filter_cond_pkg::LE: pass = (operand <= config_in.threshold);
            filter_cond_pkg::GE: pass = (operand >= config_in.threshold);
            // Unused op codes filter everything
            default:             pass = 1'b0;
        endcase
    end

    // ------------------------------------------------------------
    // Routing register
    // ------------------------------------------------------------
    // Exactly one of the two valids fires per accepted packet
    always_ff @(posedge ap_clk) begin
        if (areset_filter_cond_engine) begin
            request_engine_out.valid  <= 1'b0;
            request_control_out.valid <= 1'b0;
        end else begin
            request_engine_out.valid  <= accept & pass;
            request_control_out.valid <= accept & ~pass;
        end
        request_engine_out.payload <= response_engine_in.payload;
        request_control_out.kind   <= filter_cond_pkg::CTRL_FILTERED;
        request_control_out.id     <= response_engine_in.payload.id;
    end

    // ------------------------------------------------------------
    // Descriptor and completion tracking
    // ------------------------------------------------------------
    assign count_next = processed_q + 1'b1;

    // Target count, only meaningful once started
    always_ff @(posedge ap_clk) begin
        if (descriptor_in.valid) begin
            desc_count_q <= descriptor_in.count;
        end
    end

    // New descriptor restarts the count and drops done
    // Done is set on the edge that registers the last output
    always_ff @(posedge ap_clk) begin
        if (areset_filter_cond_engine) begin
            started_q   <= 1'b0;
            done_q      <= 1'b0;
            processed_q <= '0;
        end else if (descriptor_in.valid) begin
            started_q   <= 1'b1;
            done_q      <= 1'b0;
            processed_q <= '0;
        end else if (accept && !done_q) begin
            processed_q <= count_next;
            if (count_next == desc_count_q) begin
                done_q <= 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

/* rtl/filter_cond_engine.sv */
// ----------------------------------------------------------
// Filter-condition engine top level
// No back-pressure, output valids are single-cycle strobes
// Armed packet latency is 3 cycles from pin to pin
// Config takes 2 cycles from memory response to valid
// ----------------------------------------------------------

`default_nettype none

module filter_cond_engine (
    input  logic                             ap_clk,
    input  logic                             areset_filter_cond_engine,
    input  filter_cond_pkg::descriptor_t     descriptor_in,
    input  filter_cond_pkg::memory_response_t response_memory_in,
    input  filter_cond_pkg::engine_packet_t  response_engine_in,
    output filter_cond_pkg::engine_packet_t  request_engine_out,
    output filter_cond_pkg::control_packet_t request_control_out,
    output logic                             setup_out,
    output logic                             done_out
);

    // ------------------------------------------------------------
    // Internal signals
    // ------------------------------------------------------------
    filter_cond_pkg::descriptor_t         descriptor_reg;
    filter_cond_pkg::memory_response_t    response_memory_reg;
    filter_cond_pkg::engine_packet_t      response_engine_reg;
    filter_cond_pkg::filter_cond_config_t config_int;
    filter_cond_pkg::engine_packet_t      gen_request_engine;
    filter_cond_pkg::control_packet_t     gen_request_control;
    logic                                 gen_armed;
    logic                                 gen_done;

    // ------------------------------------------------------------
    // Ingress registers
    // ------------------------------------------------------------
    // Only the valid bits see reset, payload just follows the pins
    always_ff @(posedge ap_clk) begin
        if (areset_filter_cond_engine) begin
            descriptor_reg.valid      <= 1'b0;
            response_memory_reg.valid <= 1'b0;
            response_engine_reg.valid <= 1'b0;
        end else begin
            descriptor_reg.valid      <= descriptor_in.valid;
            response_memory_reg.valid <= response_memory_in.valid;
            response_engine_reg.valid <= response_engine_in.valid;
        end
        descriptor_reg.count        <= descriptor_in.count;
        response_memory_reg.slot    <= response_memory_in.slot;
        response_memory_reg.data    <= response_memory_in.data;
        response_engine_reg.payload <= response_engine_in.payload;
    end

    // ------------------------------------------------------------
    // Stages
    // ------------------------------------------------------------
    // Configuration capture, one cycle after ingress
    filter_cond_configure_memory u_configure_memory (
        .ap_clk                    (ap_clk),
        .areset_filter_cond_engine (areset_filter_cond_engine),
        .response_memory_in        (response_memory_reg),
        .config_out                (config_int)
    );

    // Condition evaluation and routing
    filter_cond_generator u_generator (
        .ap_clk                    (ap_clk),
        .areset_filter_cond_engine (areset_filter_cond_engine),
        .descriptor_in             (descriptor_reg),
        .config_in                 (config_int),
        .response_engine_in        (response_engine_reg),
        .request_engine_out        (gen_request_engine),
        .request_control_out       (gen_request_control),
        .armed                     (gen_armed),
        .done                      (gen_done)
    );

    // ------------------------------------------------------------
    // Egress registers
    // ------------------------------------------------------------
    // Done travels with the last output so both appear together
    // Setup stays high until config and descriptor are both in
    always_ff @(posedge ap_clk) begin
        if (areset_filter_cond_engine) begin
            request_engine_out.valid  <= 1'b0;
            request_control_out.valid <= 1'b0;
            setup_out                 <= 1'b1;
            done_out                  <= 1'b0;
        end else begin
            request_engine_out.valid  <= gen_request_engine.valid;
            request_control_out.valid <= gen_request_control.valid;
            setup_out                 <= ~gen_armed;
            done_out                  <= gen_done;
        end
        request_engine_out.payload <= gen_request_engine.payload;
        request_control_out.kind   <= gen_request_control.kind;
        request_control_out.id     <= gen_request_control.id;
    end

endmodule

`default_nettype wire

/* tb/filter_cond_assertions.sv */
// ----------------------------------------------------------
// Output protocol checks, bound into the engine top level
// Done may fall only three edges after a descriptor at the pins
// ----------------------------------------------------------

`default_nettype none

module filter_cond_assertions (
    input logic                             ap_clk,
    input logic                             areset_filter_cond_engine,
    input filter_cond_pkg::descriptor_t     descriptor_in,
    input filter_cond_pkg::engine_packet_t  request_engine_out,
    input filter_cond_pkg::control_packet_t request_control_out,
    input logic                             setup_out,
    input logic                             done_out
);

    int one_output_fails = 0;
    int done_hold_fails = 0;
    int reset_state_fails = 0;
    int failures;

    // Total seen by the testbench at the end of the run
    assign failures = one_output_fails + done_hold_fails + reset_state_fails;

    // Each accepted packet leaves on one output only
    one_output: assert property (@(posedge ap_clk) disable iff (areset_filter_cond_engine)
        !(request_engine_out.valid && request_control_out.valid))
        else begin
            $error("Both output valids high in the same cycle");
            one_output_fails++;
        end

    // Ingress, done register and egress put three edges between them
    done_hold: assert property (@(posedge ap_clk) disable iff (areset_filter_cond_engine)
        $fell(done_out) |-> $past(descriptor_in.valid, 3))
        else begin
            $error("done_out dropped without a descriptor");
            done_hold_fails++;
        end

    // Outputs idle and setup high right after a reset edge
    reset_state: assert property (@(posedge ap_clk) areset_filter_cond_engine |=>
        (!request_engine_out.valid && !request_control_out.valid && !done_out && setup_out))
        else begin
            $error("Outputs not in reset state after reset");
            reset_state_fails++;
        end

endmodule

`default_nettype wire

/* tb/filter_cond_checker.sv */
// ----------------------------------------------------------
// Scoreboard for the engine, models config, arming and done
// Input changes take effect for packets in later cycles only
// ----------------------------------------------------------

`default_nettype none

`include "filter_cond_params.svh"

module filter_cond_checker (
    input logic                              ap_clk,
    input logic                              areset_filter_cond_engine,
    input filter_cond_pkg::descriptor_t      descriptor_in,
    input filter_cond_pkg::memory_response_t response_memory_in,
    input filter_cond_pkg::engine_packet_t   response_engine_in,
    input filter_cond_pkg::engine_packet_t   request_engine_out,
    input filter_cond_pkg::control_packet_t  request_control_out,
    input logic                              done_out
);

    // One entry per armed packet, in arrival order
    typedef struct packed {
        logic                             pass;
        logic                             done_after;
        filter_cond_pkg::engine_payload_t payload;
    } expect_t;

    expect_t exp_q[$];

    // Staged and committed configuration model
    logic [2:0]             op_stage;
    logic [2:0]             op_cfg;
    logic                   field_stage;
    logic                   field_cfg;
    logic [`FC_DATA_W-1:0]  thr_stage;
    logic [`FC_DATA_W-1:0]  thr_cfg;
    logic                   cfg_valid;
    logic                   started;
    logic                   model_done;
    logic [`FC_COUNT_W-1:0] target;
    logic [`FC_COUNT_W-1:0] counted;

    int    error_count = 0;
    int    missing_count = 0;
    int    check_count = 0;
    int    test_count = 0;
    int    errors_at_start = 0;
    string test_name = "reset";

    // ------------------------------------------------------------
    // Reference condition
    // ------------------------------------------------------------
    // Unsigned compare, selected field on the left
    function automatic logic cond_holds(input logic [2:0] op, input logic field,
                                        input logic [`FC_DATA_W-1:0] thr,
                                        input filter_cond_pkg::engine_payload_t p);
        logic [`FC_DATA_W-1:0] lhs;
        logic                  below;
        logic                  equal;
        lhs = (field == filter_cond_pkg::FIELD_DATA) ? p.data : `FC_DATA_W'(p.id);
        below = lhs < thr;
        equal = lhs == thr;
        case (op)
            filter_cond_pkg::EQ: return equal;
            filter_cond_pkg::NE: return !equal;
            filter_cond_pkg::LT: return below;
            filter_cond_pkg::GT: return !below && !equal;
            filter_cond_pkg::LE: return below || equal;
            filter_cond_pkg::GE: return !below;
            // Codes 6 and 7 pass nothing
            default:             return 1'b0;
        endcase
    endfunction

    // ------------------------------------------------------------
    // Compare and model update
    // ------------------------------------------------------------
    always @(posedge ap_clk) begin
        expect_t     e;
        logic [52:0] want;
        logic [52:0] got;
        if (areset_filter_cond_engine) begin
            cfg_valid = 1'b0;
            started = 1'b0;
            model_done = 1'b0;
            counted = '0;
        end else begin
            // Outputs first, they belong to packets from earlier cycles
            if (request_engine_out.valid || request_control_out.valid) begin
                if (exp_q.size() == 0) begin
                    $display("Output seen with no packet pending in test %s", test_name);
                    error_count++;
                end else begin
                    e = exp_q.pop_front();
                    check_count++;
                    // Word is engine valid, control valid, done, kind, id, data
                    want = {e.pass, !e.pass, e.done_after,
                            e.pass ? 2'b00 : 2'(filter_cond_pkg::CTRL_FILTERED),
                            e.payload.id,
                            e.pass ? e.payload.data : {`FC_DATA_W{1'b0}}};
                    got = {request_engine_out.valid, request_control_out.valid, done_out,
                           request_engine_out.valid ? 2'b00 : 2'(request_control_out.kind),
                           request_engine_out.valid ? request_engine_out.payload.id
                                                    : request_control_out.id,
                           request_engine_out.valid ? request_engine_out.payload.data
                                                    : {`FC_DATA_W{1'b0}}};
                    if (want !== got) begin
                        $display("** Error test %s: expected %h actual %h", test_name, want, got);
                        error_count++;
                    end
                end
            end
            // Armed packets are counted until done
            if (response_engine_in.valid && cfg_valid && started) begin
                if (!model_done) begin
                    counted = counted + `FC_COUNT_W'(1);
                    model_done = (counted == target);
                end
                e.pass = cond_holds(op_cfg, field_cfg, thr_cfg, response_engine_in.payload);
                e.done_after = model_done;
                e.payload = response_engine_in.payload;
                exp_q.push_back(e);
            end
            // Slot writes, slot 3 commits
            if (response_memory_in.valid) begin
                case (response_memory_in.slot)
                    2'd0: op_stage = response_memory_in.data[2:0];
                    2'd1: thr_stage = response_memory_in.data;
                    2'd2: field_stage = response_memory_in.data[0];
                    default: begin
                        op_cfg = op_stage;
                        thr_cfg = thr_stage;
                        field_cfg = field_stage;
                        cfg_valid = 1'b1;
                    end
                endcase
            end
            if (descriptor_in.valid) begin
                started = 1'b1;
                target = descriptor_in.count;
                counted = '0;
                model_done = 1'b0;
            end
        end
    end

    // ------------------------------------------------------------
    // Reporting
    // ------------------------------------------------------------
    task automatic begin_test(input string name);
        test_name = name;
        errors_at_start = error_count;
    endtask

    task automatic end_test();
        test_count++;
        if (exp_q.size() != 0) begin
            $display("Test %s ended with %0d outputs never seen", test_name, exp_q.size());
            missing_count += exp_q.size();
        end
        $display("Test %s finished, %0d errors", test_name, error_count - errors_at_start);
    endtask

    task automatic print_summary(input int total_errors);
        $display("Summary: %0d tests, %0d outputs checked, %0d errors",
                 test_count, check_count, total_errors);
    endtask

endmodule

`default_nettype wire

/* tb/tb_filter_cond_engine.sv */
// ----------------------------------------------------------
// Testbench top for the filter-condition engine
// Inputs change on the falling edge, one item per cycle
// Data and ids are 8 bit so a threshold of 0x80 splits them
// ----------------------------------------------------------

`default_nettype none

`include "filter_cond_params.svh"

module tb_filter_cond_engine;

    localparam int          NUM_TESTS = 8;
    localparam int          PACKETS = 12;
    localparam logic [31:0] THRESHOLD = 32'h0000_0080;

    logic                             ap_clk = 1'b0;
    logic                             areset_filter_cond_engine;
    filter_cond_pkg::descriptor_t     descriptor_in;
    filter_cond_pkg::memory_response_t response_memory_in;
    filter_cond_pkg::engine_packet_t  response_engine_in;
    filter_cond_pkg::engine_packet_t  request_engine_out;
    filter_cond_pkg::control_packet_t request_control_out;
    logic                             setup_out;
    logic                             done_out;

    logic [31:0] lfsr_state = 32'h1d9e;
    int          tb_failures = 0;
    int          total_errors;

    always #4 ap_clk = ~ap_clk;

    filter_cond_engine dut (
        .ap_clk                    (ap_clk),
        .areset_filter_cond_engine (areset_filter_cond_engine),
        .descriptor_in             (descriptor_in),
        .response_memory_in        (response_memory_in),
        .response_engine_in        (response_engine_in),
        .request_engine_out        (request_engine_out),
        .request_control_out       (request_control_out),
        .setup_out                 (setup_out),
        .done_out                  (done_out)
    );

    filter_cond_checker u_checker (
        .ap_clk                    (ap_clk),
        .areset_filter_cond_engine (areset_filter_cond_engine),
        .descriptor_in             (descriptor_in),
        .response_memory_in        (response_memory_in),
        .response_engine_in        (response_engine_in),
        .request_engine_out        (request_engine_out),
        .request_control_out       (request_control_out),
        .done_out                  (done_out)
    );

    bind filter_cond_engine filter_cond_assertions u_assertions (
        .ap_clk                    (ap_clk),
        .areset_filter_cond_engine (areset_filter_cond_engine),
        .descriptor_in             (descriptor_in),
        .request_engine_out        (request_engine_out),
        .request_control_out       (request_control_out),
        .setup_out                 (setup_out),
        .done_out                  (done_out)
    );

    // Budget per test covers config, descriptor, packets and drain
    initial begin
        #(NUM_TESTS * (PACKETS + 20) * 8);
        $display("Watchdog expired, the run did not finish in time");
        $display("ERRORS FOUND");
        $finish;
    end

    // ------------------------------------------------------------
    // Stimulus helpers
    // ------------------------------------------------------------
    // Galois form, taps for x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
    endfunction

    task automatic random_bits(input int n, output logic [31:0] value);
        value = '0;
        for (int i = 0; i < n; i++) begin
            value = {value[30:0], lfsr_state[0]};
            lfsr_state = lfsr_next(lfsr_state);
        end
    endtask

    // Falling edge, all valids dropped
    task automatic next_cycle();
        @(negedge ap_clk);
        descriptor_in.valid = 1'b0;
        response_memory_in.valid = 1'b0;
        response_engine_in.valid = 1'b0;
    endtask

    task automatic write_slot(input logic [1:0] slot, input logic [31:0] data);
        next_cycle();
        response_memory_in.valid = 1'b1;
        response_memory_in.slot = slot;
        response_memory_in.data = data;
    endtask

    task automatic start_descriptor();
        next_cycle();
        descriptor_in.valid = 1'b1;
        descriptor_in.count = `FC_COUNT_W'(PACKETS);
        next_cycle();
    endtask

    // Mode 1 repeats the threshold as data, mode 2 mirrors the id
    task automatic send_packets(input int n, input int mode, input logic [31:0] thr);
        logic [31:0] id_bits;
        logic [31:0] data_bits;
        for (int i = 0; i < n; i++) begin
            random_bits(8, id_bits);
            random_bits(8, data_bits);
            if (mode == 1 && i[0]) begin
                data_bits = thr;
            end
            if (mode == 2) begin
                data_bits = {24'h0, ~id_bits[7:0]};
            end
            next_cycle();
            response_engine_in.valid = 1'b1;
            response_engine_in.payload.id = id_bits[15:0];
            response_engine_in.payload.data = data_bits;
        end
        next_cycle();
    endtask

    // Polls at falling edges, gives up after 16 cycles
    task automatic await_level(input bit on_setup, input logic want);
        int   waited;
        logic now;
        waited = 0;
        now = on_setup ? setup_out : done_out;
        while (now !== want && waited < 16) begin
            next_cycle();
            waited++;
            now = on_setup ? setup_out : done_out;
        end
        if (now !== want) begin
            $display("%s never reached %0b in test %s",
                     on_setup ? "setup_out" : "done_out", want, u_checker.test_name);
            tb_failures++;
        end
    endtask

    task automatic run_test(input string name, input filter_cond_pkg::cond_op_e op,
                            input filter_cond_pkg::field_sel_e field,
                            input logic [31:0] thr, input int mode);
        u_checker.begin_test(name);
        write_slot(2'd0, 32'(op));
        write_slot(2'd1, thr);
        write_slot(2'd2, 32'(field));
        write_slot(2'd3, 32'h0);
        start_descriptor();
        await_level(1'b1, 1'b0);
        send_packets(PACKETS, mode, thr);
        await_level(1'b0, 1'b1);
        // Last output is compared at the next rising edge
        next_cycle();
        u_checker.end_test();
    endtask

    // ------------------------------------------------------------
    // Test sequence
    // ------------------------------------------------------------
    initial begin
        descriptor_in = '0;
        response_memory_in = '0;
        response_engine_in = '0;
        areset_filter_cond_engine = 1'b1;
        repeat (4) @(posedge ap_clk);
        @(negedge ap_clk);
        areset_filter_cond_engine = 1'b0;

        // Idle outputs after reset, then packets that must be dropped
        if (request_engine_out.valid || request_control_out.valid || done_out || !setup_out) begin
            $display("Outputs not idle with setup high after reset");
            tb_failures++;
        end
        send_packets(2, 0, THRESHOLD);
        run_test("gt_data", filter_cond_pkg::GT, filter_cond_pkg::FIELD_DATA, THRESHOLD, 0);
        run_test("eq_data", filter_cond_pkg::EQ, filter_cond_pkg::FIELD_DATA, 32'h5a, 1);
        run_test("ne_data", filter_cond_pkg::NE, filter_cond_pkg::FIELD_DATA, 32'h5a, 1);
        run_test("lt_data", filter_cond_pkg::LT, filter_cond_pkg::FIELD_DATA, THRESHOLD, 0);
        run_test("le_data", filter_cond_pkg::LE, filter_cond_pkg::FIELD_DATA, 32'h70, 0);
        run_test("ge_data", filter_cond_pkg::GE, filter_cond_pkg::FIELD_DATA, 32'h90, 0);
        run_test("gt_id", filter_cond_pkg::GT, filter_cond_pkg::FIELD_ID, THRESHOLD, 2);

        // Same config, new descriptor clears done and counts again
        u_checker.begin_test("done_repeat");
        start_descriptor();
        await_level(1'b0, 1'b0);
        send_packets(PACKETS, 0, THRESHOLD);
        await_level(1'b0, 1'b1);
        next_cycle();
        u_checker.end_test();

        repeat (4) next_cycle();
        total_errors = u_checker.error_count + u_checker.missing_count
                     + dut.u_assertions.failures + tb_failures;
        u_checker.print_summary(total_errors);
        if (total_errors == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

endmodule

`default_nettype wire
